//--- project.f
+incdir+bench
hdl/axi2per_pkg.sv
hdl/axi2per_req_channel.sv
hdl/per_regfile.sv
hdl/axi2per_res_channel.sv
hdl/axi2per_top.sv
bench/tb_axi2per.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f project.f --top-module tb_axi2per -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_axi2per" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx 'All tests passed!' "$LOG"; then
  echo "Simulation PASSED"
  exit 0
fi
echo "Simulation FAILED"
exit 1

//--- bench/tb_axi2per_tasks.svh
// AXI driver tasks and register model

// Reference copy of the register file
logic [axi2per_pkg::PerDataWidth-1:0] model [axi2per_pkg::RegNum];

// Word address inside the register file
function automatic logic addr_ok(input logic [31:0] addr);
  return (addr >> 2) < axi2per_pkg::RegNum;
endfunction

// Next rising edge plus drive skew
task automatic step();
  @(posedge clk_i);
  #1;
endtask

// Ready high about one cycle in four when stalling
function automatic logic pick_ready(input bit stall);
  if (!stall) begin
    return 1'b1;
  end
  return ($random(seed) & 3) == 0;
endfunction

// Holds R or B ready until the handshake, checked at the falling edge
task automatic take_response(input bit read, input bit stall);
  logic rdy;
  logic done;
  done = 1'b0;
  while (!done) begin
    rdy     = pick_ready(stall);
    r_ready = read & rdy;
    b_ready = ~read & rdy;
    @(negedge clk_i);
    done = read ? (r_valid & r_ready) : (b_valid & b_ready);
    step();
  end
  r_ready = 1'b0;
  b_ready = 1'b0;
endtask

task automatic axi_write(input logic [31:0] addr, input logic [3:0] id,
                         input logic [63:0] data, input logic [7:0] strb, input bit stall);
  logic [31:0] word;
  logic [3:0]  be;
  // Address bit 2 picks the upper half
  word = addr[2] ? data[63:32] : data[31:0];
  be   = addr[2] ? strb[7:4] : strb[3:0];
  exp_b_id   = id;
  exp_b_resp = addr_ok(addr) ? axi2per_pkg::RespOkay : axi2per_pkg::RespSlvErr;
  // Only enabled bytes of an in-range word change
  if (addr_ok(addr)) begin
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        model[addr[5:2]][8*b +: 8] = word[8*b +: 8];
      end
    end
  end
  wr_owed  = 1'b1;
  aw_addr  = addr;
  aw_id    = id;
  w_data   = data;
  w_strb   = strb;
  aw_valid = 1'b1;
  w_valid  = 1'b1;
  @(negedge clk_i);
  while (!(aw_ready && w_ready)) begin
    @(negedge clk_i);
  end
  step();
  aw_valid = 1'b0;
  w_valid  = 1'b0;
  take_response(1'b0, stall);
  wr_owed = 1'b0;
endtask

task automatic axi_read(input logic [31:0] addr, input logic [3:0] id, input bit stall);
  ar_addr  = addr;
  ar_id    = id;
  ar_valid = 1'b1;
  @(negedge clk_i);
  while (!ar_ready) begin
    @(negedge clk_i);
  end
  // Expected data fixed at acceptance, after any write that went first
  exp_r_id   = id;
  exp_r_resp = addr_ok(addr) ? axi2per_pkg::RespOkay : axi2per_pkg::RespSlvErr;
  exp_r_data = '0;
  if (addr_ok(addr)) begin
    exp_r_data = addr[2] ? {model[addr[5:2]], 32'h0} : {32'h0, model[addr[5:2]]};
  end
  step();
  ar_valid = 1'b0;
  take_response(1'b1, stall);
endtask

//--- bench/tb_axi2per.sv
// AXI to peripheral bridge testbench
`timescale 1ns/1ps

module tb_axi2per;

  // Reset reads, round trip, strobes, range, priority, back-pressure
  localparam int unsigned NumTrans = 16 + 40 + 24 + 9 + 8 + 20;
  // Watchdog in ns from 20 cycles of 10 ns per transaction plus margin
  localparam int unsigned Timeout  = (NumTrans * 20 + 100) * 10;

  logic                                  clk_i;
  logic                                  rst_ni;
  logic                                  ar_valid, ar_ready, aw_valid, aw_ready;
  logic                                  w_valid, w_ready, r_valid, r_ready, r_last;
  logic                                  b_valid, b_ready;
  logic [axi2per_pkg::AxiAddrWidth-1:0]  ar_addr, aw_addr;
  logic [axi2per_pkg::AxiIdWidth-1:0]    ar_id, aw_id, r_id, b_id;
  logic [axi2per_pkg::AxiDataWidth-1:0]  w_data, r_data;
  logic [axi2per_pkg::AxiStrbWidth-1:0]  w_strb;
  logic [1:0]                            r_resp, b_resp;
  logic                                  accept;
  logic                                  busy;

  // Expected response fields filled in by the driver tasks
  logic [axi2per_pkg::AxiDataWidth-1:0]  exp_r_data;
  logic [1:0]                            exp_r_resp, exp_b_resp;
  logic [axi2per_pkg::AxiIdWidth-1:0]    exp_r_id, exp_b_id;
  // Write still owes its B response
  logic                                  wr_owed;
  int                                    seed;
  int                                    err_cnt, err_mark, tests_pass, tests_fail;

  axi2per_top uut (
    .clk_i, .rst_ni,
    .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_addr_i (ar_addr), .ar_id_i (ar_id),
    .aw_valid_i (aw_valid), .aw_ready_o (aw_ready), .aw_addr_i (aw_addr), .aw_id_i (aw_id),
    .w_valid_i (w_valid), .w_ready_o (w_ready), .w_data_i (w_data), .w_strb_i (w_strb),
    .r_valid_o (r_valid), .r_ready_i (r_ready), .r_data_o (r_data), .r_resp_o (r_resp),
    .r_last_o (r_last), .r_id_o (r_id),
    .b_valid_o (b_valid), .b_ready_i (b_ready), .b_resp_o (b_resp), .b_id_o (b_id)
  );

  always #5 clk_i = ~clk_i;

  `include "tb_axi2per_tasks.svh"

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    err_cnt++;
    $display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
  endtask

  task automatic report_event(input string what);
    err_cnt++;
    $display("Check failed at %0d ns: %s", $time, what);
  endtask

  // One result line per test
  task automatic finish_test(input string name);
    if (err_cnt == err_mark) begin
      tests_pass++;
      $display("PASS %s", name);
    end else begin
      tests_fail++;
      $display("FAIL %s with %0d errors", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // ******************************
  // Protocol and data checks
  // ******************************

  assign accept = (ar_valid && ar_ready) || (aw_valid && aw_ready && w_valid && w_ready);

  // Bridge busy from acceptance until the response handshake
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy <= 1'b0;
    end else if (accept) begin
      busy <= 1'b1;
    end else if ((r_valid && r_ready) || (b_valid && b_ready)) begin
      busy <= 1'b0;
    end
  end

  // Idle outputs right after reset release
  assert property (@(posedge clk_i)
      $rose(rst_ni) |-> ar_ready && aw_ready && w_ready && !r_valid && !b_valid)
    else report_event("ready or valid outputs wrong after reset");

  // Values at the R handshake
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid && r_ready |-> r_data == exp_r_data)
    else report_mismatch("r_data", exp_r_data, r_data);
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid && r_ready |-> r_resp == exp_r_resp)
    else report_mismatch("r_resp", 64'(exp_r_resp), 64'(r_resp));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid && r_ready |-> r_id == exp_r_id)
    else report_mismatch("r_id", 64'(exp_r_id), 64'(r_id));
  assert property (@(posedge clk_i) disable iff (!rst_ni) r_valid |-> r_last)
    else report_mismatch("r_last", 64'd1, 64'(r_last));

  // Values at the B handshake
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      b_valid && b_ready |-> b_resp == exp_b_resp)
    else report_mismatch("b_resp", 64'(exp_b_resp), 64'(b_resp));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      b_valid && b_ready |-> b_id == exp_b_id)
    else report_mismatch("b_id", 64'(exp_b_id), 64'(b_id));

  // Write wins so no read data while a write is unanswered
  assert property (@(posedge clk_i) disable iff (!rst_ni) r_valid |-> !wr_owed)
    else report_event("read answered before the competing write");

  // Stalled responses hold still
  assert property (@(posedge clk_i) disable iff (!rst_ni) r_valid && !r_ready
      |=> r_valid && $stable(r_data) && $stable(r_resp) && $stable(r_id))
    else report_event("R channel changed while stalled");
  assert property (@(posedge clk_i) disable iff (!rst_ni) b_valid && !b_ready
      |=> b_valid && $stable(b_resp) && $stable(b_id))
    else report_event("B channel changed while stalled");

  // No ready output from acceptance until the response handshake
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      busy |-> !(ar_ready || aw_ready || w_ready))
    else report_event("ready output high before the response handshake");

  // Three cycles from acceptance to response valid
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(r_valid || b_valid) |-> $past(accept, 3))
    else report_event("response valid not three cycles after acceptance");

  // ******************************
  // Test sequence
  // ******************************

  initial begin
    logic [31:0] addr;
    seed   = 32'h4cea_33cf;
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    {ar_valid, aw_valid, w_valid, r_ready, b_ready, wr_owed} = '0;
    {ar_addr, aw_addr, ar_id, aw_id} = '0;
    {w_data, w_strb} = '0;
    for (int i = 0; i < axi2per_pkg::RegNum; i++) begin
      model[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    for (int i = 0; i < axi2per_pkg::RegNum; i++) begin
      axi_read(32'(i * 4), 4'(i), 1'b0);
    end
    finish_test("reset contents");

    repeat (20) begin
      addr = 32'(($random(seed) & 15) * 4);
      axi_write(addr, 4'($random(seed)), {$random(seed), $random(seed)}, 8'hFF, 1'b0);
      axi_read(addr, 4'($random(seed)), 1'b0);
    end
    finish_test("full word round trip");

    repeat (12) begin
      addr = 32'(($random(seed) & 15) * 4);
      axi_write(addr, 4'($random(seed)), {$random(seed), $random(seed)},
                8'($random(seed)), 1'b0);
      axi_read(addr, 4'($random(seed)), 1'b0);
    end
    finish_test("byte strobes");

    // Word index bits reused above the file so aliasing would show
    repeat (3) begin
      addr = 32'h40 + 32'(($random(seed) & 255) * 4);
      axi_write(addr, 4'h3, {$random(seed), $random(seed)}, 8'hFF, 1'b0);
      axi_read(addr, 4'h5, 1'b0);
      axi_read(addr & 32'h3C, 4'h6, 1'b0);
    end
    finish_test("out of range");

    repeat (4) begin
      addr = 32'(($random(seed) & 15) * 4);
      fork
        axi_write(addr, 4'($random(seed)), {$random(seed), $random(seed)}, 8'hFF, 1'b0);
        axi_read(addr, 4'($random(seed)), 1'b0);
      join
    end
    finish_test("ids and write priority");

    repeat (10) begin
      addr = 32'(($random(seed) & 15) * 4);
      axi_write(addr, 4'($random(seed)), {$random(seed), $random(seed)},
                8'($random(seed)), 1'b1);
      axi_read(addr, 4'($random(seed)), 1'b1);
    end
    finish_test("back-pressure");

    $display("Summary: %0d tests passed, %0d tests failed", tests_pass, tests_fail);
    if (tests_fail == 0 && err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Hang guard
  initial begin
    #(Timeout);
    $display("Watchdog expired, the bridge stopped responding");
    $display("Test failures found");
    $finish;
  end

endmodule

//--- hdl/axi2per_top.sv
// AXI to peripheral bridge top
`timescale 1ns/1ps

module axi2per_top (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // AXI read address
  input  logic                                  ar_valid_i,
  output logic                                  ar_ready_o,
  input  logic [axi2per_pkg::AxiAddrWidth-1:0]  ar_addr_i,
  input  logic [axi2per_pkg::AxiIdWidth-1:0]    ar_id_i,

  // AXI write address
  input  logic                                  aw_valid_i,
  output logic                                  aw_ready_o,
  input  logic [axi2per_pkg::AxiAddrWidth-1:0]  aw_addr_i,
  input  logic [axi2per_pkg::AxiIdWidth-1:0]    aw_id_i,

  // AXI write data
  input  logic                                  w_valid_i,
  output logic                                  w_ready_o,
  input  logic [axi2per_pkg::AxiDataWidth-1:0]  w_data_i,
  input  logic [axi2per_pkg::AxiStrbWidth-1:0]  w_strb_i,

  // AXI read data
  output logic                                  r_valid_o,
  input  logic                                  r_ready_i,
  output logic [axi2per_pkg::AxiDataWidth-1:0]  r_data_o,
  output logic [1:0]                            r_resp_o,
  output logic                                  r_last_o,
  output logic [axi2per_pkg::AxiIdWidth-1:0]    r_id_o,

  // AXI write response
  output logic                                  b_valid_o,
  input  logic                                  b_ready_i,
  output logic [1:0]                            b_resp_o,
  output logic [axi2per_pkg::AxiIdWidth-1:0]    b_id_o
);

  // ******************************
  // Internal buses
  // ******************************

  // Peripheral request and response
  logic                                  per_req, per_gnt, per_wen;
  logic [axi2per_pkg::AxiAddrWidth-1:0]  per_addr;
  logic [axi2per_pkg::PerDataWidth-1:0]  per_wdata;
  logic [axi2per_pkg::PerBeWidth-1:0]    per_be;
  logic                                  per_r_valid, per_r_opc;
  logic [axi2per_pkg::PerDataWidth-1:0]  per_r_rdata;

  // Transaction handover
  logic                                  trans_req, trans_wen, trans_done;
  logic [axi2per_pkg::AxiIdWidth-1:0]    trans_id;
  logic [axi2per_pkg::AxiAddrWidth-1:0]  trans_addr;

  axi2per_req_channel i_req_channel (
    .clk_i, .rst_ni,
    .ar_valid_i, .ar_ready_o, .ar_addr_i, .ar_id_i,
    .aw_valid_i, .aw_ready_o, .aw_addr_i, .aw_id_i,
    .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i,
    .per_req_o (per_req), .per_gnt_i (per_gnt), .per_addr_o (per_addr),
    .per_wen_o (per_wen), .per_wdata_o (per_wdata), .per_be_o (per_be),
    .trans_req_o (trans_req), .trans_wen_o (trans_wen), .trans_id_o (trans_id),
    .trans_addr_o (trans_addr), .trans_done_i (trans_done)
  );

  per_regfile i_regfile (
    .clk_i, .rst_ni,
    .per_req_i (per_req), .per_gnt_o (per_gnt), .per_addr_i (per_addr),
    .per_wen_i (per_wen), .per_wdata_i (per_wdata), .per_be_i (per_be),
    .per_r_valid_o (per_r_valid), .per_r_opc_o (per_r_opc), .per_r_rdata_o (per_r_rdata)
  );

  axi2per_res_channel i_res_channel (
    .clk_i, .rst_ni,
    .per_r_valid_i (per_r_valid), .per_r_opc_i (per_r_opc), .per_r_rdata_i (per_r_rdata),
    .r_valid_o, .r_ready_i, .r_data_o, .r_resp_o, .r_last_o, .r_id_o,
    .b_valid_o, .b_ready_i, .b_resp_o, .b_id_o,
    .trans_req_i (trans_req), .trans_wen_i (trans_wen), .trans_id_i (trans_id),
    .trans_addr_i (trans_addr), .trans_done_o (trans_done)
  );

endmodule

//--- hdl/axi2per_res_channel.sv
// AXI response channel
`timescale 1ns/1ps

module axi2per_res_channel (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Peripheral response
  input  logic                                  per_r_valid_i,
  input  logic                                  per_r_opc_i,
  input  logic [axi2per_pkg::PerDataWidth-1:0]  per_r_rdata_i,

  // AXI read data
  output logic                                  r_valid_o,
  input  logic                                  r_ready_i,
  output logic [axi2per_pkg::AxiDataWidth-1:0]  r_data_o,
  output logic [1:0]                            r_resp_o,
  output logic                                  r_last_o,
  output logic [axi2per_pkg::AxiIdWidth-1:0]    r_id_o,

  // AXI write response
  output logic                                  b_valid_o,
  input  logic                                  b_ready_i,
  output logic [1:0]                            b_resp_o,
  output logic [axi2per_pkg::AxiIdWidth-1:0]    b_id_o,

  // Transaction info from the request channel
  input  logic                                  trans_req_i,
  input  logic                                  trans_wen_i,
  input  logic [axi2per_pkg::AxiIdWidth-1:0]    trans_id_i,
  input  logic [axi2per_pkg::AxiAddrWidth-1:0]  trans_addr_i,
  output logic                                  trans_done_o
);

  typedef enum logic {ResIdle, ResPending} state_e;

  state_e                                state_d, state_q;
  logic                                  pending;
  logic                                  read_q;   // High for a read
  logic                                  lane_q;   // High for the upper half
  logic [axi2per_pkg::AxiIdWidth-1:0]    id_q;
  logic                                  opc_q;
  logic [axi2per_pkg::PerDataWidth-1:0]  rdata_q;
  logic [1:0]                            resp;

  // ******************************
  // Response FSM
  // ******************************

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ResIdle: begin
        if (per_r_valid_i) begin
          state_d = ResPending;
        end
      end
      ResPending: begin
        // Leave once the master takes R or B
        if (trans_done_o) begin
          state_d = ResIdle;
        end
      end
      default: state_d = ResIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Transaction info and peripheral data
  always_ff @(posedge clk_i) begin
    if (trans_req_i) begin
      read_q <= trans_wen_i;
      lane_q <= trans_addr_i[axi2per_pkg::LaneBit];
      id_q   <= trans_id_i;
    end
    if (per_r_valid_i) begin
      opc_q   <= per_r_opc_i;
      rdata_q <= per_r_rdata_i;
    end
  end

  // ******************************
  // AXI outputs
  // ******************************

  assign pending = (state_q == ResPending);
  assign resp    = (opc_q == axi2per_pkg::OpcErr) ? axi2per_pkg::RespSlvErr
                                                  : axi2per_pkg::RespOkay;

  assign r_valid_o = pending & read_q;
  assign r_last_o  = r_valid_o;  // Single beat only
  assign r_resp_o  = resp;
  assign r_id_o    = id_q;
  // Data in the selected half, other half zero
  assign r_data_o  = lane_q ? {rdata_q, {axi2per_pkg::PerDataWidth{1'b0}}}
                            : {{axi2per_pkg::PerDataWidth{1'b0}}, rdata_q};

  assign b_valid_o = pending & ~read_q;
  assign b_resp_o  = resp;
  assign b_id_o    = id_q;

  assign trans_done_o = (r_valid_o & r_ready_i) | (b_valid_o & b_ready_i);

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      per_r_valid_i |-> state_q == ResIdle)
    else $error("Peripheral response lost while pending");

endmodule

//--- hdl/per_regfile.sv
// Peripheral register file
`timescale 1ns/1ps

module per_regfile (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Request
  input  logic                                  per_req_i,
  output logic                                  per_gnt_o,
  input  logic [axi2per_pkg::AxiAddrWidth-1:0]  per_addr_i,
  input  logic                                  per_wen_i,
  input  logic [axi2per_pkg::PerDataWidth-1:0]  per_wdata_i,
  input  logic [axi2per_pkg::PerBeWidth-1:0]    per_be_i,

  // Response one cycle after grant
  output logic                                  per_r_valid_o,
  output logic                                  per_r_opc_o,
  output logic [axi2per_pkg::PerDataWidth-1:0]  per_r_rdata_o
);

  logic [axi2per_pkg::PerDataWidth-1:0] mem_q [axi2per_pkg::RegNum];
  logic [axi2per_pkg::RegIdxWidth-1:0]  idx;
  logic                                 in_range;
  logic                                 taken;

  // Single-cycle access that never stalls
  assign per_gnt_o = 1'b1;
  assign taken     = per_req_i & per_gnt_o;

  // Word index with the byte offset dropped
  assign idx      = per_addr_i[axi2per_pkg::RegIdxWidth+1:2];
  // Any set bit above the index is outside the file
  assign in_range = ~|per_addr_i[axi2per_pkg::AxiAddrWidth-1:axi2per_pkg::RegIdxWidth+2];

  // Storage with byte enables
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < axi2per_pkg::RegNum; i++) begin
        mem_q[i] <= '0;
      end
    end else if (taken && !per_wen_i && in_range) begin
      for (int b = 0; b < axi2per_pkg::PerBeWidth; b++) begin
        if (per_be_i[b]) begin
          mem_q[idx][8*b +: 8] <= per_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Response valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      per_r_valid_o <= 1'b0;
    end else begin
      per_r_valid_o <= taken;
    end
  end

  // Response payload with zero data for writes and errors
  always_ff @(posedge clk_i) begin
    if (taken) begin
      per_r_opc_o   <= in_range ? axi2per_pkg::OpcOk : axi2per_pkg::OpcErr;
      per_r_rdata_o <= (per_wen_i && in_range) ? mem_q[idx] : '0;
    end
  end

endmodule

//--- hdl/axi2per_req_channel.sv
// AXI request channel
`timescale 1ns/1ps

module axi2per_req_channel (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // AXI read address
  input  logic                                  ar_valid_i,
  output logic                                  ar_ready_o,
  input  logic [axi2per_pkg::AxiAddrWidth-1:0]  ar_addr_i,
  input  logic [axi2per_pkg::AxiIdWidth-1:0]    ar_id_i,

  // AXI write address
  input  logic                                  aw_valid_i,
  output logic                                  aw_ready_o,
  input  logic [axi2per_pkg::AxiAddrWidth-1:0]  aw_addr_i,
  input  logic [axi2per_pkg::AxiIdWidth-1:0]    aw_id_i,

  // AXI write data
  input  logic                                  w_valid_i,
  output logic                                  w_ready_o,
  input  logic [axi2per_pkg::AxiDataWidth-1:0]  w_data_i,
  input  logic [axi2per_pkg::AxiStrbWidth-1:0]  w_strb_i,

  // Peripheral request
  output logic                                  per_req_o,
  input  logic                                  per_gnt_i,
  output logic [axi2per_pkg::AxiAddrWidth-1:0]  per_addr_o,
  output logic                                  per_wen_o,
  output logic [axi2per_pkg::PerDataWidth-1:0]  per_wdata_o,
  output logic [axi2per_pkg::PerBeWidth-1:0]    per_be_o,

  // Transaction info towards the response channel
  output logic                                  trans_req_o,
  output logic                                  trans_wen_o,
  output logic [axi2per_pkg::AxiIdWidth-1:0]    trans_id_o,
  output logic [axi2per_pkg::AxiAddrWidth-1:0]  trans_addr_o,
  input  logic                                  trans_done_i
);

  typedef enum logic [1:0] {ReqIdle, ReqIssue, ReqWait} state_e;

  state_e                                state_d, state_q;
  logic                                  idle;
  logic                                  write_both;
  logic                                  write_go;
  logic                                  accept;
  logic [axi2per_pkg::PerDataWidth-1:0]  lane_wdata;
  logic [axi2per_pkg::PerBeWidth-1:0]    lane_be;
  logic [axi2per_pkg::AxiAddrWidth-1:0]  addr_q;
  logic                                  wen_q;
  logic [axi2per_pkg::PerDataWidth-1:0]  wdata_q;
  logic [axi2per_pkg::PerBeWidth-1:0]    be_q;

  // ******************************
  // AXI acceptance
  // ******************************

  assign idle       = (state_q == ReqIdle);
  assign write_both = aw_valid_i & w_valid_i;
  // Write wins over a read offered in the same cycle
  assign write_go   = idle & write_both;
  assign accept     = write_go | (idle & ar_valid_i);

  // AW and W only transfer as a pair
  // AR held off while a write is offered
  assign ar_ready_o = idle & ~write_both;
  assign aw_ready_o = idle & (w_valid_i | ~aw_valid_i);
  assign w_ready_o  = idle & (aw_valid_i | ~w_valid_i);

  // Info for the response channel valid in the accepting cycle
  assign trans_req_o  = accept;
  assign trans_wen_o  = ~write_go;  // High for a read
  assign trans_id_o   = write_go ? aw_id_i : ar_id_i;
  assign trans_addr_o = write_go ? aw_addr_i : ar_addr_i;

  // Pick the 32-bit half of data and strobes
  always_comb begin
    if (aw_addr_i[axi2per_pkg::LaneBit]) begin
      lane_wdata = w_data_i[axi2per_pkg::AxiDataWidth-1:axi2per_pkg::PerDataWidth];
      lane_be    = w_strb_i[axi2per_pkg::AxiStrbWidth-1:axi2per_pkg::PerBeWidth];
    end else begin
      lane_wdata = w_data_i[axi2per_pkg::PerDataWidth-1:0];
      lane_be    = w_strb_i[axi2per_pkg::PerBeWidth-1:0];
    end
  end

  // ******************************
  // Request FSM
  // ******************************

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ReqIdle: begin
        if (accept) begin
          state_d = ReqIssue;
        end
      end
      ReqIssue: begin
        // Hold the request until granted
        if (per_gnt_i) begin
          state_d = ReqWait;
        end
      end
      ReqWait: begin
        if (trans_done_i) begin
          state_d = ReqIdle;
        end
      end
      default: state_d = ReqIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ReqIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload captured on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= trans_addr_o;
      wen_q   <= ~write_go;
      wdata_q <= write_go ? lane_wdata : '0;
      be_q    <= write_go ? lane_be : '0;
    end
  end

  assign per_req_o   = (state_q == ReqIssue);
  assign per_addr_o  = addr_q;
  assign per_wen_o   = wen_q;
  assign per_wdata_o = wdata_q;
  assign per_be_o    = be_q;

  // Completion only arrives for a granted request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      trans_done_i |-> state_q == ReqWait)
    else $error("Transaction done without an outstanding request");

endmodule

//--- hdl/axi2per_pkg.sv
// AXI to peripheral bridge definitions
package axi2per_pkg;

  // ******************************
  // AXI slave port
  // ******************************

  // Address width, shared with the peripheral bus
  localparam int unsigned AxiAddrWidth = 32;
  // Full 64-bit data lane
  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned AxiStrbWidth = AxiDataWidth / 8;
  localparam int unsigned AxiIdWidth   = 4;

  // Address bit choosing the upper 32-bit half of the lane
  localparam int unsigned LaneBit = 2;

  // AXI response codes
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  // ******************************
  // Peripheral bus
  // ******************************

  localparam int unsigned PerDataWidth = 32;
  localparam int unsigned PerBeWidth   = PerDataWidth / 8;

  // Response opcodes
  localparam logic OpcOk  = 1'b0;
  localparam logic OpcErr = 1'b1;

  // ******************************
  // Register file
  // ******************************

  // Word count, a power of two
  localparam int unsigned RegNum      = 16;
  localparam int unsigned RegIdxWidth = $clog2(RegNum);

endpackage
